/* logic/lane_comparator.sv */
// one adc phase; even lanes are channel 0 and odd lanes channel 1, any non-falling type uses rising polarity
`timescale 1ns/1ps

module lane_comparator import trig_pkg::*; #(
   parameter int LANE = 0
) (
   input  logic       clklvds,
   input  logic       reset,
   input  sample_t    lane_samples [N_PER_LANE],
   input  sample_t    lower_q,
   input  sample_t    upper_q,
   input  trig_type_t type_q,
   input  logic       two_channel_q,
   input  logic       chan_q,
   output lane_mask_t arm_mask,
   output lane_mask_t fire_mask
);

   localparam logic LANE_CHAN = 1'(LANE % 2);

   logic       falling;
   logic       lane_on;
   lane_mask_t arm_d;
   lane_mask_t fire_d;

   assign falling = (type_q == TRIG_FALLING);
   assign lane_on = !two_channel_q || (chan_q == LANE_CHAN);   // single channel uses every lane

   always_comb begin
      arm_d  = '0;
      fire_d = '0;
      for (int i = 0; i < N_PER_LANE; i++) begin
         // earliest sample lands in the top bit so a larger mask means an earlier crossing
         if (falling) begin
            arm_d[N_PER_LANE-1-i]  = lane_samples[i] > upper_q;
            fire_d[N_PER_LANE-1-i] = lane_samples[i] < lower_q;
         end else begin
            arm_d[N_PER_LANE-1-i]  = lane_samples[i] < lower_q;
            fire_d[N_PER_LANE-1-i] = lane_samples[i] > upper_q;
         end
      end
   end

   always_ff @(posedge clklvds) begin
      if (reset) begin
         arm_mask  <= '0;
         fire_mask <= '0;
      end else begin
         arm_mask  <= lane_on ? arm_d : '0;
         fire_mask <= lane_on ? fire_d : '0;
      end
   end

endmodule

/* logic/phase_picker.sv */
// phase and mask keep the last capture; an auto trigger leaves them unchanged
`timescale 1ns/1ps

module phase_picker import trig_pkg::*; (
   input  logic       clklvds,
   input  logic       reset,
   input  logic       capture,
   input  lane_mask_t fire_masks [N_LANES],
   output phase_t     trigger_phase,
   output lane_mask_t fire_mask_out
);

   lane_mask_t masks_q [N_LANES];
   lane_mask_t best_mask;
   phase_t     best_lane;

   always_ff @(posedge clklvds) begin
      if (reset) begin
         for (int k = 0; k < N_LANES; k++) begin
            masks_q[k] <= '0;
         end
      end else if (capture) begin
         masks_q <= fire_masks;
      end
   end

   // largest mask is the earliest crossing, strict compare keeps the lower lane on a tie
   always_comb begin
      best_mask = masks_q[0];
      best_lane = '0;
      for (int k = 1; k < N_LANES; k++) begin
         if (masks_q[k] > best_mask) begin
            best_mask = masks_q[k];
            best_lane = phase_t'(k);
         end
      end
   end

   assign trigger_phase = best_lane;
   assign fire_mask_out = best_mask;

endmodule

/* logic/sample_decimator.sv */
// settings and samples are sampled once on clklvds with no synchronizer; merging of 0 acts as 1
`timescale 1ns/1ps

module sample_decimator import trig_pkg::*; (
   input  logic       clklvds,
   input  logic       reset,
   input  sample_t    samples [N_SAMPLES],
   input  sample_t    lower_thresh,
   input  sample_t    upper_thresh,
   input  trig_type_t trig_type,
   input  logic       two_channel,
   input  logic       trig_chan,
   input  decim_t     decimation,
   input  merge_t     merging,
   input  logic       write_en,
   output sample_t    samples_q [N_SAMPLES],
   output sample_t    lower_q,
   output sample_t    upper_q,
   output trig_type_t type_q,
   output logic       two_channel_q,
   output logic       chan_q,
   output logic       write_stb,
   output logic       ram_wr,
   output ram_addr_t  ram_wr_address
);

   decim_t      decimation_q;
   merge_t      merging_q;
   logic [31:0] decim_cnt;    // runs 1 .. 2**decimation
   merge_t      merge_cnt;    // runs 1 .. merging

   always_ff @(posedge clklvds) begin
      samples_q <= samples;
      lower_q   <= lower_thresh;
      upper_q   <= upper_thresh;
   end

   always_ff @(posedge clklvds) begin
      if (reset) begin
         type_q        <= TRIG_OFF;
         two_channel_q <= 1'b0;
         chan_q        <= 1'b0;
         decimation_q  <= '0;
         merging_q     <= 8'd1;
      end else begin
         type_q        <= trig_type;
         two_channel_q <= two_channel;
         chan_q        <= trig_chan;
         decimation_q  <= decimation;
         merging_q     <= merging;
      end
   end

   // strobe and address change on the same edge, so the address is valid with ram_wr
   always_ff @(posedge clklvds) begin
      if (reset) begin
         decim_cnt      <= 32'd1;
         merge_cnt      <= 8'd1;
         write_stb      <= 1'b0;
         ram_wr_address <= '0;
      end else if (!write_en) begin
         decim_cnt <= 32'd1;                        // restart the period on every new run
         merge_cnt <= 8'd1;
         write_stb <= 1'b0;
      end else if (decim_cnt[decimation_q]) begin
         decim_cnt <= 32'd1;
         if (merge_cnt >= merging_q) begin
            merge_cnt      <= 8'd1;
            write_stb      <= 1'b1;
            ram_wr_address <= ram_wr_address + 1'b1;
         end else begin
            merge_cnt <= merge_cnt + 1'b1;
            write_stb <= 1'b0;
         end
      end else begin
         decim_cnt <= decim_cnt + 1'b1;
         write_stb <= 1'b0;
      end
   end

   assign ram_wr = write_stb;

endmodule

/* logic/trig_pkg.sv */
// shared widths and codes for the four-phase trigger; only the rising, falling and auto codes start an acquisition

package trig_pkg;

   localparam int N_LANES    = 4;                      // interleaved adc phases
   localparam int N_PER_LANE = 10;                     // samples per lane per clock
   localparam int N_SAMPLES  = N_LANES * N_PER_LANE;   // samples per clock
   localparam int SAMPLE_W   = 12;
   localparam int ADDR_W     = 10;

   typedef logic signed [SAMPLE_W-1:0] sample_t;
   typedef logic [N_PER_LANE-1:0]      lane_mask_t;    // bit 9 is the first sample of the lane
   typedef logic [ADDR_W-1:0]          ram_addr_t;

   typedef logic [15:0] count_t;    // pre and post lengths in write strobes
   typedef logic [7:0]  tot_t;      // time over threshold in write strobes
   typedef logic [7:0]  merge_t;
   typedef logic [4:0]  decim_t;    // strobe period is 2**decim_t
   typedef logic [1:0]  phase_t;
   typedef logic [31:0] time_t;     // clklvds cycles, wraps
   typedef logic [7:0]  trig_type_t;

   localparam trig_type_t TRIG_OFF     = 8'd0;
   localparam trig_type_t TRIG_RISING  = 8'd1;
   localparam trig_type_t TRIG_FALLING = 8'd2;
   localparam trig_type_t TRIG_AUTO    = 8'd4;

   // acquisition sequence, hold waits for the readout handshake
   typedef enum logic [2:0] {
      ACQ_IDLE,
      ACQ_PRE,
      ACQ_ARM,
      ACQ_FIRE,
      ACQ_AUTO,
      ACQ_POST,
      ACQ_HOLD
   } acq_state_t;

endpackage

/* logic/trigger_fsm.sv */
// pre_len, post_len and tot_len are used unregistered and must stay static during an acquisition
`timescale 1ns/1ps

module trigger_fsm import trig_pkg::*; (
   input  logic       clklvds,
   input  logic       reset,
   input  trig_type_t type_q,
   input  logic       write_stb,
   input  ram_addr_t  ram_wr_address,
   input  logic       arm_any,
   input  logic       fire_any,
   input  count_t     pre_len,
   input  count_t     post_len,
   input  tot_t       tot_len,
   input  logic       event_ready,
   output logic       write_en,
   output logic       capture,
   output ram_addr_t  trigger_address,
   output time_t      event_time,
   output logic       event_valid,
   output acq_state_t acq_state
);

   acq_state_t state;
   acq_state_t state_next;
   trig_type_t active_type;    // type seen when the run started
   count_t     rel_cnt;        // strobes since entering pre or post
   count_t     rel_cnt_inc;
   tot_t       tot_cnt;
   time_t      time_cnt;
   logic       captured;
   logic       type_changed;
   logic       fire_done;
   logic       trig_now;

   assign rel_cnt_inc  = rel_cnt + count_t'(write_stb);   // includes the strobe of this cycle
   assign type_changed = (type_q != active_type);
   assign fire_done    = fire_any && (tot_cnt >= tot_len);
   assign trig_now     = (state_next == ACQ_POST) && (state != ACQ_POST);

   always_comb begin
      state_next = state;
      case (state)
         ACQ_IDLE: begin
            if (type_q == TRIG_RISING || type_q == TRIG_FALLING || type_q == TRIG_AUTO) begin
               state_next = ACQ_PRE;
            end
         end
         ACQ_PRE: begin
            if (type_changed) begin
               state_next = ACQ_IDLE;
            end else if (rel_cnt_inc >= pre_len) begin
               state_next = (active_type == TRIG_AUTO) ? ACQ_AUTO : ACQ_ARM;
            end
         end
         ACQ_ARM: begin
            if (type_changed) state_next = ACQ_IDLE;
            else if (arm_any) state_next = ACQ_FIRE;      // first step of the edge
         end
         ACQ_FIRE: begin
            if (type_changed) state_next = ACQ_IDLE;
            else if (fire_done) state_next = ACQ_POST;
         end
         ACQ_AUTO: state_next = ACQ_POST;                 // unconditional trigger
         ACQ_POST: begin
            if (rel_cnt_inc >= post_len) state_next = ACQ_HOLD;
         end
         ACQ_HOLD: begin
            if (event_ready) state_next = ACQ_IDLE;
         end
         default: state_next = ACQ_IDLE;
      endcase
   end

   // the decimator registers its strobe from this, so it follows the next state
   always_comb begin
      case (state_next)
         ACQ_IDLE, ACQ_HOLD: write_en = 1'b0;
         ACQ_POST:           write_en = (state == ACQ_POST) || (post_len != '0);
         default:            write_en = 1'b1;
      endcase
   end

   always_ff @(posedge clklvds) begin
      if (reset) begin
         state       <= ACQ_IDLE;
         active_type <= TRIG_OFF;
         rel_cnt     <= '0;
         tot_cnt     <= '0;
         captured    <= 1'b0;
         time_cnt    <= '0;
      end else begin
         state    <= state_next;
         time_cnt <= time_cnt + 1'b1;
         if (state == ACQ_IDLE) active_type <= type_q;

         if (state_next != state) rel_cnt <= '0;
         else if (write_stb) rel_cnt <= rel_cnt_inc;

         // time over threshold restarts whenever the fire condition drops
         if (state == ACQ_FIRE && fire_any) begin
            if (write_stb && !fire_done) tot_cnt <= tot_cnt + 1'b1;
            captured <= 1'b1;
         end else begin
            tot_cnt  <= '0;
            captured <= 1'b0;
         end
      end
   end

   always_ff @(posedge clklvds) begin
      if (trig_now) begin
         trigger_address <= ram_wr_address - ram_addr_t'(tot_len);   // back to the first fire strobe
         event_time      <= time_cnt;
      end
   end

   assign capture     = (state == ACQ_FIRE) && fire_any && !captured;
   assign event_valid = (state == ACQ_HOLD);
   assign acq_state   = state;

endmodule

/* logic/trigger_top.sv */
// top of the trigger and ram write controller; ram data path and readout are outside this block
`timescale 1ns/1ps

module trigger_top import trig_pkg::*; (
   input  logic       clklvds,
   input  logic       reset,
   input  sample_t    samples [N_SAMPLES],
   input  sample_t    lower_thresh,
   input  sample_t    upper_thresh,
   input  trig_type_t trig_type,
   input  logic       two_channel,
   input  logic       trig_chan,
   input  decim_t     decimation,
   input  merge_t     merging,
   input  count_t     pre_len,
   input  count_t     post_len,
   input  tot_t       tot_len,
   input  logic       event_ready,
   output logic       ram_wr,
   output ram_addr_t  ram_wr_address,
   output logic       event_valid,
   output ram_addr_t  trigger_address,
   output time_t      event_time,
   output phase_t     trigger_phase,
   output lane_mask_t fire_mask_out
);

   sample_t    samples_q [N_SAMPLES];
   sample_t    lower_q;
   sample_t    upper_q;
   trig_type_t type_q;
   logic       two_channel_q;
   logic       chan_q;
   logic       write_stb;
   logic       write_en;
   logic       capture;
   lane_mask_t arm_masks [N_LANES];
   lane_mask_t fire_masks [N_LANES];
   logic       arm_any;
   logic       fire_any;

   sample_decimator u_decim (
      .clklvds        (clklvds),
      .reset          (reset),
      .samples        (samples),
      .lower_thresh   (lower_thresh),
      .upper_thresh   (upper_thresh),
      .trig_type      (trig_type),
      .two_channel    (two_channel),
      .trig_chan      (trig_chan),
      .decimation     (decimation),
      .merging        (merging),
      .write_en       (write_en),
      .samples_q      (samples_q),
      .lower_q        (lower_q),
      .upper_q        (upper_q),
      .type_q         (type_q),
      .two_channel_q  (two_channel_q),
      .chan_q         (chan_q),
      .write_stb      (write_stb),
      .ram_wr         (ram_wr),
      .ram_wr_address (ram_wr_address)
   );

   for (genvar g = 0; g < N_LANES; g++) begin : g_lane
      sample_t lane_s [N_PER_LANE];
      for (genvar j = 0; j < N_PER_LANE; j++) begin : g_map
         assign lane_s[j] = samples_q[g*N_PER_LANE + j];   // lane g owns a block of ten
      end
      lane_comparator #(.LANE(g)) u_lane (
         .clklvds       (clklvds),
         .reset         (reset),
         .lane_samples  (lane_s),
         .lower_q       (lower_q),
         .upper_q       (upper_q),
         .type_q        (type_q),
         .two_channel_q (two_channel_q),
         .chan_q        (chan_q),
         .arm_mask      (arm_masks[g]),
         .fire_mask     (fire_masks[g])
      );
   end

   assign arm_any  = |(arm_masks[0] | arm_masks[1] | arm_masks[2] | arm_masks[3]);
   assign fire_any = |(fire_masks[0] | fire_masks[1] | fire_masks[2] | fire_masks[3]);

   trigger_fsm u_fsm (
      .clklvds         (clklvds),
      .reset           (reset),
      .type_q          (type_q),
      .write_stb       (write_stb),
      .ram_wr_address  (ram_wr_address),
      .arm_any         (arm_any),
      .fire_any        (fire_any),
      .pre_len         (pre_len),
      .post_len        (post_len),
      .tot_len         (tot_len),
      .event_ready     (event_ready),
      .write_en        (write_en),
      .capture         (capture),
      .trigger_address (trigger_address),
      .event_time      (event_time),
      .event_valid     (event_valid),
      .acq_state       ()
   );

   phase_picker u_phase (
      .clklvds       (clklvds),
      .reset         (reset),
      .capture       (capture),
      .fire_masks    (fire_masks),
      .trigger_phase (trigger_phase),
      .fire_mask_out (fire_mask_out)
   );

endmodule

/* run.sh */
#!/bin/sh
# compile and run the trigger testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -Wno-fatal \
   --top-module trigger_tb -f vlog.f \
   --Mdir obj_dir -o trigger_sim

out=$(./obj_dir/trigger_sim)
echo "$out"

if echo "$out" | grep -q "Result: PASSED"; then
   exit 0
fi
exit 1

/* sim/trigger_chk.sv */
// bound into every trigger_fsm; checks hold only outside reset
`timescale 1ns/1ps

module trigger_chk import trig_pkg::*; (
   input logic      clklvds,
   input logic      reset,
   input logic      event_valid,
   input logic      event_ready,
   input ram_addr_t trigger_address,
   input logic      capture,
   input logic      write_stb
);

   // record waits for the readout
   a_hold_record: assert property (@(posedge clklvds) disable iff (reset)
      event_valid && !event_ready |=> event_valid && $stable(trigger_address))
      else $error("event record dropped or changed before event_ready");

   a_no_write_in_hold: assert property (@(posedge clklvds) disable iff (reset)
      !(write_stb && event_valid))
      else $error("ram write while the event record is pending");

   a_capture_pulse: assert property (@(posedge clklvds) disable iff (reset)
      capture |=> !capture)
      else $error("capture longer than one cycle");

endmodule

bind trigger_fsm trigger_chk u_chk (.*);

/* sim/trigger_tb.sv */
// testbench for trigger_top; sample noise stays inside the thresholds, and settings change only while idle
`timescale 1ns/1ps

module trigger_tb import trig_pkg::*; ();

   // per test (pre + post + tot + 20) * 2**decimation * merging, plus a global margin
   localparam int TIMEOUT = (5 + 7 + 0 + 20) + (4 + 6 + 0 + 20) * 4 * 3 + (8 + 6 + 0 + 20)
                          + (8 + 6 + 2 + 20) + (8 + 6 + 0 + 20) + 2 * (6 + 6 + 0 + 20) + 200;

   logic       clklvds;
   logic       reset;
   sample_t    samples [N_SAMPLES];
   sample_t    lower_thresh;
   sample_t    upper_thresh;
   trig_type_t trig_type;
   logic       two_channel;
   logic       trig_chan;
   decim_t     decimation;
   merge_t     merging;
   count_t     pre_len;
   count_t     post_len;
   tot_t       tot_len;
   logic       event_ready;
   logic       ram_wr;
   ram_addr_t  ram_wr_address;
   logic       event_valid;
   ram_addr_t  trigger_address;
   time_t      event_time;
   phase_t     trigger_phase;
   lane_mask_t fire_mask_out;

   int err_addr = 0;
   int err_phase = 0;
   int err_mask = 0;
   int err_other = 0;
   int cycles = 0;
   int events = 0;
   int gaps_seen = 0;
   int last_stb = -1;
   logic                      phase_check_en = 1'b0;
   logic                      gap_check_en = 1'b0;
   logic                      in_event = 1'b0;
   ram_addr_t                 exp_addr = '0;
   phase_t                    exp_phase;
   lane_mask_t                exp_mask;
   lane_mask_t [N_LANES-1:0]  inj;
   ram_addr_t                 rec_addr;
   ram_addr_t                 rec_end;
   time_t                     rec_time;
   phase_t                    rec_phase;
   lane_mask_t                rec_mask;
   time_t                     tb_time = '0;
   time_t                     addr_time [2**ADDR_W];   // cycle at which each address was current

   trigger_top dut0 (.*);

   initial begin
      clklvds = 1'b0;
      forever #4 clklvds = ~clklvds;
   end

   // largest mask read unsigned wins and the lower lane keeps a tie
   function automatic logic [11:0] ref_phase(input lane_mask_t [N_LANES-1:0] m);
      phase_t     p;
      lane_mask_t best;
      p    = phase_t'(N_LANES-1);
      best = m[N_LANES-1];
      for (int k = N_LANES-2; k >= 0; k--) begin
         if (m[k] >= best) begin
            best = m[k];
            p    = phase_t'(k);
         end
      end
      return {p, best};
   endfunction

   function automatic sample_t noise();
      return sample_t'(int'($urandom % 401) - 200);   // stays within +-200
   endfunction

   task automatic check_addr(input string name, input ram_addr_t got, input ram_addr_t exp);
      if (got !== exp) begin
         err_addr++;
         $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic check_phase(input string name, input phase_t got, input phase_t exp);
      if (got !== exp) begin
         err_phase++;
         $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic check_mask(input string name, input lane_mask_t got, input lane_mask_t exp);
      if (got !== exp) begin
         err_mask++;
         $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic check_time(input string name, input time_t got, input time_t exp);
      if (got !== exp) begin
         err_other++;
         $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic check_count(input string name, input count_t got, input count_t exp);
      if (got !== exp) begin
         err_other++;
         $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
      end
   endtask

   // samples flagged in m take level and the rest get fresh noise each cycle
   task automatic drive_pattern(input lane_mask_t [N_LANES-1:0] m, input sample_t level,
                                input int n);
      repeat (n) begin
         @(negedge clklvds);
         for (int g = 0; g < N_LANES; g++) begin
            for (int j = 0; j < N_PER_LANE; j++) begin
               samples[g*N_PER_LANE + j] = m[g][N_PER_LANE-1-j] ? level : noise();
            end
         end
      end
   endtask

   task automatic set_run(input trig_type_t t, input decim_t d, input merge_t mg,
                          input count_t pre, input count_t post, input tot_t tot);
      @(negedge clklvds);
      decimation = d;
      merging    = mg;
      pre_len    = pre;
      post_len   = post;
      tot_len    = tot;
      trig_type  = t;
      drive_pattern('0, '0, 1);
   endtask

   // waits for the record, holds ready low, then accepts and parks the FSM in idle
   task automatic finish_event(input int hold);
      @(negedge clklvds);
      while (!event_valid) @(negedge clklvds);
      repeat (hold) @(negedge clklvds);
      trig_type   = TRIG_OFF;
      event_ready = 1'b1;
      @(negedge clklvds);
      event_ready = 1'b0;
      repeat (2) @(negedge clklvds);
   endtask

   // compare process on the falling edge where registered outputs are settled
   always @(negedge clklvds) begin
      if (reset) begin
         exp_addr = '0;
         last_stb = -1;
      end else begin
         addr_time[ram_wr_address] = tb_time;
         if (ram_wr) begin
            exp_addr = exp_addr + 1'b1;
            if (gap_check_en && last_stb >= 0) begin
               check_count("ram_wr gap", count_t'(cycles - last_stb), count_t'(12));
               gaps_seen++;
            end
            last_stb = cycles;
         end
         check_addr("ram_wr_address", ram_wr_address, exp_addr);
         if (event_valid && !in_event) begin
            in_event = 1'b1;
            events++;
            last_stb = -1;
            check_addr("ram_wr_address at event", ram_wr_address,
                       trigger_address + ram_addr_t'(tot_len) + ram_addr_t'(post_len));
            if (decimation == 5'd0 && merging == 8'd1 && post_len != '0) begin
               // one strobe per cycle puts the trigger cycle post_len addresses back
               check_time("event_time", event_time,
                          addr_time[ram_wr_address - ram_addr_t'(post_len)]);
            end
            if (phase_check_en) begin
               check_phase("trigger_phase", trigger_phase, exp_phase);
               check_mask("fire_mask_out", fire_mask_out, exp_mask);
            end
            rec_addr  = trigger_address;
            rec_end   = ram_wr_address;
            rec_time  = event_time;
            rec_phase = trigger_phase;
            rec_mask  = fire_mask_out;
         end else if (event_valid) begin
            check_addr("trigger_address", trigger_address, rec_addr);   // record held
            check_addr("ram_wr_address in hold", ram_wr_address, rec_end);
            check_time("event_time", event_time, rec_time);
            check_phase("trigger_phase", trigger_phase, rec_phase);
            check_mask("fire_mask_out", fire_mask_out, rec_mask);
         end else begin
            in_event = 1'b0;
         end
      end
   end

   always @(posedge clklvds) begin
      cycles++;
      if (reset) begin
         tb_time = '0;
      end else begin
         tb_time = tb_time + 1'b1;    // same count as the free-running event clock
      end
      if (cycles >= TIMEOUT) begin
         $display("timeout: no result after %0d cycles", cycles);
         $display("Result: FAILED");
         $finish;
      end
   end

   initial begin
      int hold;
      int ev0;
      logic [11:0] r;
      void'($urandom(32'h9d49));
      reset        = 1'b1;
      lower_thresh = -12'sd500;
      upper_thresh = 12'sd500;
      trig_type    = TRIG_OFF;
      two_channel  = 1'b0;
      trig_chan    = 1'b0;
      decimation   = '0;
      merging      = 8'd1;
      pre_len      = '0;
      post_len     = '0;
      tot_len      = '0;
      event_ready  = 1'b0;
      for (int i = 0; i < N_SAMPLES; i++) samples[i] = '0;
      repeat (4) @(posedge clklvds);
      @(negedge clklvds);
      reset = 1'b0;

      // auto trigger with a strobe every cycle
      set_run(TRIG_AUTO, 5'd0, 8'd1, 16'd5, 16'd7, 8'd0);
      finish_event(0);

      // decimation 4 times merging 3 gives one strobe per 12 cycles
      gap_check_en = 1'b1;
      set_run(TRIG_AUTO, 5'd2, 8'd3, 16'd4, 16'd6, 8'd0);
      finish_event(0);
      gap_check_en = 1'b0;
      if (gaps_seen < 5) begin
         err_other++;
         $display("too few write strobe gaps measured in the decimation test");
      end

      // rising edge with a crossing on lane 2 only
      set_run(TRIG_RISING, 5'd0, 8'd1, 16'd8, 16'd6, 8'd0);
      drive_pattern({N_LANES{10'h3ff}}, -12'sd1000, 16);
      inj    = '0;
      inj[2] = 10'b0011010010;
      r = ref_phase(inj);
      {exp_phase, exp_mask} = r;
      phase_check_en = 1'b1;
      drive_pattern(inj, 12'sd1000, 6);
      drive_pattern('0, '0, 1);
      finish_event(0);

      // falling edge with a tie between lanes 1 and 2
      set_run(TRIG_FALLING, 5'd0, 8'd1, 16'd8, 16'd6, 8'd2);
      drive_pattern({N_LANES{10'h3ff}}, 12'sd1000, 16);
      inj[0] = 10'b0000001111;
      inj[1] = 10'b0110000000;
      inj[2] = 10'b0110000000;
      inj[3] = 10'b0001111000;
      r = ref_phase(inj);
      {exp_phase, exp_mask} = r;
      drive_pattern(inj, -12'sd1000, 8);
      drive_pattern('0, '0, 1);
      finish_event(0);

      // two channel mode where channel 1 owns lanes 1 and 3
      two_channel = 1'b1;
      trig_chan   = 1'b1;
      set_run(TRIG_RISING, 5'd0, 8'd1, 16'd8, 16'd6, 8'd0);
      ev0 = events;
      inj    = '0;
      inj[0] = 10'h3ff;
      inj[2] = 10'h3ff;
      drive_pattern(inj, -12'sd1000, 16);
      drive_pattern(inj, 12'sd1000, 6);
      drive_pattern('0, '0, 10);
      if (events != ev0 || event_valid) begin
         err_other++;
         $display("event from lanes of the unselected channel in two channel mode");
      end
      inj    = '0;
      inj[3] = 10'h3ff;
      drive_pattern(inj, -12'sd1000, 4);
      inj[3] = 10'b1000000001;
      r = ref_phase(inj);    // gated lanes carry zero masks
      {exp_phase, exp_mask} = r;
      drive_pattern(inj, 12'sd1000, 6);
      drive_pattern('0, '0, 1);
      finish_event(0);
      two_channel    = 1'b0;
      trig_chan      = 1'b0;
      phase_check_en = 1'b0;

      // back-pressure and then a normal event
      hold = 3 + int'($urandom % 15);
      set_run(TRIG_AUTO, 5'd0, 8'd1, 16'd6, 16'd6, 8'd0);
      finish_event(hold);
      set_run(TRIG_AUTO, 5'd0, 8'd1, 16'd6, 16'd6, 8'd0);
      finish_event(0);

      if (events != 7) begin
         err_other++;
         $display("expected 7 events but saw %0d", events);
      end
      repeat (3) @(negedge clklvds);
      $display("errors: addr %0d phase %0d mask %0d other %0d",
               err_addr, err_phase, err_mask, err_other);
      if (err_addr + err_phase + err_mask + err_other == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

/* vlog.f */
logic/trig_pkg.sv
logic/sample_decimator.sv
logic/lane_comparator.sv
logic/trigger_fsm.sv
logic/phase_picker.sv
logic/trigger_top.sv
sim/trigger_chk.sv
sim/trigger_tb.sv
